// ==== src/fb_pkg.sv ====
/* Shared widths, register map and enums for the framebuffer display subsystem.
   Blocks refer to these by scoped name. */
package fb_pkg;

    localparam int CIDXW = 4;   // colour index bits
    localparam int CHANW = 4;   // bits per palette channel
    localparam int CORDW = 16;  // raster and buffer coordinates

    // paint opcodes, written to REG_CTRL[1:0]
    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0,
        CMD_FILL = 2'd1,
        CMD_BOX  = 2'd2
    } fb_cmd_e;

    // box_painter states
    typedef enum logic [2:0] {
        P_IDLE,
        P_WAIT_FRAME,  // command held until next frame pulse
        P_FILL,
        P_TOP,
        P_RIGHT,
        P_BOTTOM,
        P_LEFT
    } paint_state_e;

    // APB register map
    localparam logic [7:0] REG_CTRL     = 8'h00;  // [1:0] opcode, [7:4] index
    localparam logic [7:0] REG_STATUS   = 8'h04;  // [0] busy, [15:8] done count
    localparam logic [7:0] REG_PAL_BASE = 8'h40;  // 16 entries, stride 4

endpackage

// ==== src/display_timing.sv ====
/* Raster timing generator. Free-running counters plus registered sync, data
   enable and frame-start decodes, all aligned with sx and sy. */
`timescale 1ns/10ps

module display_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33
) (
    input  logic                      clk_pix,
    input  logic                      reset,
    output logic [fb_pkg::CORDW-1:0]  sx,
    output logic [fb_pkg::CORDW-1:0]  sy,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output logic                      frame
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_START = H_ACTIVE + H_FP;
    localparam int VS_START = V_ACTIVE + V_FP;

    logic [fb_pkg::CORDW-1:0] sx_next, sy_next;

    always_comb begin
        sx_next = sx + 1'b1;
        sy_next = sy;
        if (sx == fb_pkg::CORDW'(H_TOTAL - 1)) begin
            sx_next = '0;
            if (sy == fb_pkg::CORDW'(V_TOTAL - 1))
                sy_next = '0;
            else
                sy_next = sy + 1'b1;
        end
    end

    // decodes use the next position so they line up with the counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx    <= fb_pkg::CORDW'(H_TOTAL - 1);  // first pixel after reset is (0,0)
            sy    <= fb_pkg::CORDW'(V_TOTAL - 1);
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= (sx_next >= HS_START) && (sx_next < HS_START + H_SYNC);
            vsync <= (sy_next >= VS_START) && (sy_next < VS_START + V_SYNC);
            de    <= (sx_next < H_ACTIVE) && (sy_next < V_ACTIVE);
            frame <= (sx_next == 0) && (sy_next == fb_pkg::CORDW'(V_ACTIVE));
        end
    end

endmodule

// ==== src/fb_regs.sv ====
/* APB slave for the display. Holds the paint command register, the status
   register and a readable shadow of the palette. No wait states. */
`timescale 1ns/10ps

module fb_regs (
    input  logic                       clk_pix,
    input  logic                       reset,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    input  logic                       busy,
    input  logic                       done,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       cmd_valid,
    output fb_pkg::fb_cmd_e            cmd_op,
    output logic [fb_pkg::CIDXW-1:0]   cmd_cidx,
    output logic                       pal_we,
    output logic [fb_pkg::CIDXW-1:0]   pal_addr,
    output logic [3*fb_pkg::CHANW-1:0] pal_data
);

    logic [3*fb_pkg::CHANW-1:0] pal_shadow [2**fb_pkg::CIDXW];
    logic [7:0]                 done_cnt;
    logic                       busy_flag;  // set on accepted CTRL write
    logic                       busy_any;
    logic                       access;
    logic                       is_ctrl, is_status, is_pal;
    logic [fb_pkg::CIDXW-1:0]   pal_idx;
    logic                       wr_ok;

    assign pready    = 1'b1;
    assign access    = psel && penable;
    assign busy_any  = busy_flag || busy;
    assign is_ctrl   = (paddr == fb_pkg::REG_CTRL);
    assign is_status = (paddr == fb_pkg::REG_STATUS);
    assign is_pal    = (paddr[7:6] == fb_pkg::REG_PAL_BASE[7:6]) && (paddr[1:0] == 2'b00);
    assign pal_idx   = paddr[5:2];

    assign pslverr = access && (!(is_ctrl || is_status || is_pal)
                                || (pwrite && is_status)
                                || (pwrite && is_ctrl && busy_any));
    assign wr_ok   = access && pwrite && !pslverr;

    always_comb begin
        prdata = '0;
        if (is_ctrl)
            prdata = {24'b0, cmd_cidx, 2'b0, cmd_op};
        else if (is_status)
            prdata = {16'b0, done_cnt, 7'b0, busy_any};
        else if (is_pal)
            prdata = {20'b0, pal_shadow[pal_idx]};
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            cmd_op    <= fb_pkg::CMD_NOP;
            cmd_cidx  <= '0;
            busy_flag <= 1'b0;
            done_cnt  <= '0;
            pal_we    <= 1'b0;
            for (int i = 0; i < 2**fb_pkg::CIDXW; i++)
                pal_shadow[i] <= '0;
        end else begin
            cmd_valid <= wr_ok && is_ctrl;
            pal_we    <= wr_ok && is_pal;
            if (wr_ok && is_ctrl) begin
                cmd_op    <= fb_pkg::fb_cmd_e'(pwdata[1:0]);
                cmd_cidx  <= pwdata[7:4];
                busy_flag <= 1'b1;
            end else if (done) begin
                busy_flag <= 1'b0;
            end
            if (done)
                done_cnt <= done_cnt + 1'b1;  // wraps at 256
            if (wr_ok && is_pal)
                pal_shadow[pal_idx] <= pwdata[11:0];
        end
    end

    // palette copy for the framebuffer, one cycle after the access
    always_ff @(posedge clk_pix) begin
        pal_addr <= pal_idx;
        pal_data <= pwdata[11:0];
    end

    a_penable_psel: assert property (@(posedge clk_pix) disable iff (reset)
        penable |-> psel);

    // painter must be idle whenever a new command is issued
    a_cmd_idle: assert property (@(posedge clk_pix) disable iff (reset)
        cmd_valid |-> !busy);

endmodule

// ==== src/box_painter.sv ====
/* Paint engine. Takes a command from the register block, waits for the
   frame pulse, then writes fill or outline pixels one per cycle. */
`timescale 1ns/10ps

module box_painter #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic                      clk_pix,
    input  logic                      reset,
    input  logic                      frame,
    input  logic                      cmd_valid,
    input  fb_pkg::fb_cmd_e           cmd_op,
    input  logic [fb_pkg::CIDXW-1:0]  cmd_cidx,
    output logic                      busy,
    output logic                      done,
    output logic                      we,
    output logic [fb_pkg::CORDW-1:0]  wx,
    output logic [fb_pkg::CORDW-1:0]  wy,
    output logic [fb_pkg::CIDXW-1:0]  wcidx
);

    localparam logic [fb_pkg::CORDW-1:0] X_MAX = fb_pkg::CORDW'(FB_WIDTH - 1);
    localparam logic [fb_pkg::CORDW-1:0] Y_MAX = fb_pkg::CORDW'(FB_HEIGHT - 1);

    fb_pkg::paint_state_e state;
    fb_pkg::fb_cmd_e      op;
    logic                 x_last, y_last;

    assign x_last = (wx == X_MAX);
    assign y_last = (wy == Y_MAX);
    assign busy   = (state != fb_pkg::P_IDLE);
    assign we     = busy && (state != fb_pkg::P_WAIT_FRAME);

    // pulse on the last write, or straight away for a NOP
    assign done = (state == fb_pkg::P_FILL && x_last && y_last)
               || (state == fb_pkg::P_BOTTOM && x_last)
               || (state == fb_pkg::P_WAIT_FRAME && frame
                   && op != fb_pkg::CMD_FILL && op != fb_pkg::CMD_BOX);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= fb_pkg::P_IDLE;
        end else begin
            case (state)
                fb_pkg::P_IDLE:
                    if (cmd_valid) state <= fb_pkg::P_WAIT_FRAME;
                fb_pkg::P_WAIT_FRAME:
                    if (frame) begin
                        if (op == fb_pkg::CMD_FILL)     state <= fb_pkg::P_FILL;
                        else if (op == fb_pkg::CMD_BOX) state <= fb_pkg::P_TOP;
                        else                            state <= fb_pkg::P_IDLE;
                    end
                fb_pkg::P_FILL:
                    if (x_last && y_last) state <= fb_pkg::P_IDLE;
                fb_pkg::P_TOP:
                    if (x_last) state <= fb_pkg::P_RIGHT;
                fb_pkg::P_RIGHT:
                    if (y_last) state <= fb_pkg::P_LEFT;
                fb_pkg::P_LEFT:
                    if (y_last) state <= fb_pkg::P_BOTTOM;
                fb_pkg::P_BOTTOM:
                    if (x_last) state <= fb_pkg::P_IDLE;
                default: state <= fb_pkg::P_IDLE;
            endcase
        end
    end

    // coordinates and colour, no reset needed
    always_ff @(posedge clk_pix) begin
        if (state == fb_pkg::P_IDLE && cmd_valid) begin
            op    <= cmd_op;
            wcidx <= cmd_cidx;
        end
        case (state)
            fb_pkg::P_WAIT_FRAME: begin
                wx <= '0;
                wy <= '0;
            end
            fb_pkg::P_FILL:  // raster order
                if (!x_last) begin
                    wx <= wx + 1'b1;
                end else begin
                    wx <= '0;
                    wy <= wy + 1'b1;
                end
            fb_pkg::P_TOP, fb_pkg::P_BOTTOM:
                if (!x_last) wx <= wx + 1'b1;
            fb_pkg::P_RIGHT:
                if (!y_last) begin
                    wy <= wy + 1'b1;
                end else begin
                    wx <= '0;  // back to top left for the left edge
                    wy <= '0;
                end
            fb_pkg::P_LEFT:
                if (!y_last) wy <= wy + 1'b1;
            default: ;
        endcase
    end

    a_write_in_buffer: assert property (@(posedge clk_pix) disable iff (reset)
        we |-> (wx < FB_WIDTH) && (wy < FB_HEIGHT));

endmodule

// ==== src/framebuffer.sv ====
/* Colour-index framebuffer with painter write port, scaled scan-out and a
   16-entry palette. Output lags sx, sy and de by 3 cycles. */
`timescale 1ns/10ps

module framebuffer #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int SCALE     = 4
) (
    input  logic                       clk_pix,
    input  logic                       reset,
    input  logic [fb_pkg::CORDW-1:0]   sx,
    input  logic [fb_pkg::CORDW-1:0]   sy,
    input  logic                       de,
    input  logic                       we,
    input  logic [fb_pkg::CORDW-1:0]   wx,
    input  logic [fb_pkg::CORDW-1:0]   wy,
    input  logic [fb_pkg::CIDXW-1:0]   wcidx,
    input  logic                       pal_we,
    input  logic [fb_pkg::CIDXW-1:0]   pal_addr,
    input  logic [3*fb_pkg::CHANW-1:0] pal_data,
    output logic [fb_pkg::CHANW-1:0]   red,
    output logic [fb_pkg::CHANW-1:0]   green,
    output logic [fb_pkg::CHANW-1:0]   blue
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int AW        = $clog2(FB_PIXELS);
    localparam int V_ACT     = FB_HEIGHT * SCALE;

    logic [fb_pkg::CIDXW-1:0]   mem [FB_PIXELS];
    logic [3*fb_pkg::CHANW-1:0] palette [2**fb_pkg::CIDXW];

    logic [fb_pkg::CORDW-1:0] fx, fy;        // buffer position of current pixel
    logic [fb_pkg::CORDW-1:0] x_sub, y_sub;  // position inside a scaled pixel
    logic                     line_end;
    logic [AW-1:0]            rd_addr, wr_addr;
    logic [fb_pkg::CIDXW-1:0] rd_cidx;
    logic                     de_1, de_2;

    initial begin
        for (int i = 0; i < FB_PIXELS; i++)
            mem[i] = '0;
    end

    assign wr_addr  = AW'(wy * FB_WIDTH + wx);
    assign line_end = de && (sx == fb_pkg::CORDW'(FB_WIDTH * SCALE - 1));

    // scale counters step the buffer address every SCALE pixels and lines
    always_ff @(posedge clk_pix) begin
        if (reset || !de) begin
            fx    <= '0;
            x_sub <= '0;
        end else if (x_sub == fb_pkg::CORDW'(SCALE - 1)) begin
            x_sub <= '0;
            fx    <= fx + 1'b1;
        end else begin
            x_sub <= x_sub + 1'b1;
        end

        if (reset || sy >= V_ACT) begin  // vertical blanking
            fy    <= '0;
            y_sub <= '0;
        end else if (line_end) begin
            if (y_sub == fb_pkg::CORDW'(SCALE - 1)) begin
                y_sub <= '0;
                fy    <= fy + 1'b1;
            end else begin
                y_sub <= y_sub + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we)
            mem[wr_addr] <= wcidx;
        rd_addr <= AW'(fy * FB_WIDTH + fx);       // stage 1
        rd_cidx <= mem[rd_addr];                  // stage 2
        if (de_2)                                 // stage 3
            {red, green, blue} <= palette[rd_cidx];
        else
            {red, green, blue} <= '0;             // black in blanking
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            de_1 <= 1'b0;
            de_2 <= 1'b0;
            for (int i = 0; i < 2**fb_pkg::CIDXW; i++)
                palette[i] <= '0;
        end else begin
            de_1 <= de;
            de_2 <= de_1;
            if (pal_we)
                palette[pal_addr] <= pal_data;
        end
    end

endmodule

// ==== src/fb_display_top.sv ====
/* Top level of the framebuffer display. Connects timing, registers, painter
   and framebuffer, and lines the sync signals up with the pixel pipeline. */
`timescale 1ns/10ps

module fb_display_top #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int SCALE     = 4,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33
) (
    input  logic        clk_pix,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        video_de,
    output logic        video_hsync,
    output logic        video_vsync,
    output logic [7:0]  video_red,
    output logic [7:0]  video_green,
    output logic [7:0]  video_blue
);

    localparam int H_ACTIVE = FB_WIDTH * SCALE;
    localparam int V_ACTIVE = FB_HEIGHT * SCALE;

    logic [fb_pkg::CORDW-1:0]   sx, sy, wx, wy;
    logic                       hsync, vsync, de, frame;
    logic                       busy, done, we, cmd_valid, pal_we;
    fb_pkg::fb_cmd_e            cmd_op;
    logic [fb_pkg::CIDXW-1:0]   cmd_cidx, wcidx, pal_addr;
    logic [3*fb_pkg::CHANW-1:0] pal_data;
    logic [fb_pkg::CHANW-1:0]   fb_red, fb_green, fb_blue;
    logic [2:0]                 hsync_d, vsync_d, de_d;  // 3-cycle delay lines

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) display_timing_i (
        .clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame
    );

    fb_regs fb_regs_i (
        .clk_pix, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .busy, .done, .prdata, .pready, .pslverr,
        .cmd_valid, .cmd_op, .cmd_cidx, .pal_we, .pal_addr, .pal_data
    );

    box_painter #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) box_painter_i (
        .clk_pix, .reset, .frame, .cmd_valid, .cmd_op, .cmd_cidx,
        .busy, .done, .we, .wx, .wy, .wcidx
    );

    framebuffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE)) framebuffer_i (
        .clk_pix, .reset, .sx, .sy, .de, .we, .wx, .wy, .wcidx,
        .pal_we, .pal_addr, .pal_data,
        .red(fb_red), .green(fb_green), .blue(fb_blue)
    );

    // match address, memory and palette stages
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_d <= '0;
            vsync_d <= '0;
            de_d    <= '0;
        end else begin
            hsync_d <= {hsync_d[1:0], hsync};
            vsync_d <= {vsync_d[1:0], vsync};
            de_d    <= {de_d[1:0], de};
        end
    end

    assign video_hsync = hsync_d[2];
    assign video_vsync = vsync_d[2];
    assign video_de    = de_d[2];
    assign video_red   = {fb_red, fb_red};      // nibble duplication to 8 bits
    assign video_green = {fb_green, fb_green};
    assign video_blue  = {fb_blue, fb_blue};

endmodule

// ==== tb/tb_fb_ref.svh ====
/* Testbench helpers included into the testbench top: random source, buffer
   and palette model with the expected pixel, value check and APB tasks. */
`ifndef TB_FB_REF_SVH
`define TB_FB_REF_SVH

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// expected 24-bit colour of screen pixel (px, ly) with nibbles widened
function automatic logic [23:0] expected_rgb(input int px, input int ly);
    logic [11:0] c;
    c = pal_model[buf_model[ly / SCALE][px / SCALE]];
    return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
endfunction

function automatic logic [7:0] pal_reg(input int n);
    return fb_pkg::REG_PAL_BASE + 8'(4 * n);
endfunction

task automatic model_fill(input logic [3:0] c);
    for (int y = 0; y < FB_HEIGHT; y++)
        for (int x = 0; x < FB_WIDTH; x++)
            buf_model[y][x] = c;
endtask

task automatic model_box(input logic [3:0] c);
    for (int x = 0; x < FB_WIDTH; x++) begin
        buf_model[0][x]           = c;
        buf_model[FB_HEIGHT-1][x] = c;
    end
    for (int y = 0; y < FB_HEIGHT; y++) begin
        buf_model[y][0]          = c;
        buf_model[y][FB_WIDTH-1] = c;
    end
endtask

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first mismatch");
    end
endtask

// setup phase then access phase sampled mid-cycle
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    @(posedge clk_pix);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk_pix);
    #1;
    penable = 1'b1;
    @(negedge clk_pix);
    check_equal(32'(pready), 32'h1, $sformatf("pready on write to %h", addr));
    check_equal(32'(pslverr), 32'(exp_err), $sformatf("pslverr on write to %h", addr));
    @(posedge clk_pix);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
    @(posedge clk_pix);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk_pix);
    #1;
    penable = 1'b1;
    @(negedge clk_pix);
    data = prdata;
    check_equal(32'(pready), 32'h1, $sformatf("pready on read of %h", addr));
    check_equal(32'(pslverr), 32'(exp_err), $sformatf("pslverr on read of %h", addr));
    @(posedge clk_pix);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
endtask

`endif

// ==== tb/tb_fb_display.sv ====
/* Testbench top for the framebuffer display. Sets up the palette over APB,
   paints fill and outline commands and checks timing and every output pixel. */
`timescale 1ns/10ps

module tb_fb_display;

    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 12;
    localparam int SCALE     = 4;
    localparam int H_FP      = 4;
    localparam int H_SYNC    = 8;
    localparam int H_BP      = 4;
    localparam int V_FP      = 2;
    localparam int V_SYNC    = 2;
    localparam int V_BP      = 2;
    localparam int H_ACTIVE  = FB_WIDTH * SCALE;
    localparam int V_ACTIVE  = FB_HEIGHT * SCALE;
    localparam int H_TOTAL   = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL   = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam longint WATCHDOG_NS = 10 * H_TOTAL * V_TOTAL * 40;  // 10 frames

    logic        clk_pix, reset;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic        video_de, video_hsync, video_vsync;
    logic [7:0]  video_red, video_green, video_blue;

    logic [31:0] lfsr_state;
    logic [3:0]  buf_model [FB_HEIGHT][FB_WIDTH];
    logic [11:0] pal_model [16];
    logic        check_en;     // compare pixels in this window
    int          pix_checked;
    int          px, ly, hs_cnt, hs_high, vs_high;
    logic        de_q, hs_q, vs_q, hs_seen;

    `include "tb_fb_ref.svh"

    fb_display_top #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) fb_display_top_i (
        .clk_pix, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .video_de, .video_hsync, .video_vsync,
        .video_red, .video_green, .video_blue
    );

    always #20 clk_pix = ~clk_pix;

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h1;
        while (st[0])
            apb_read(fb_pkg::REG_STATUS, st, 1'b0);
    endtask

    // one whole frame from vsync to vsync
    task automatic check_frame();
        @(posedge video_vsync);
        pix_checked = 0;
        check_en    = 1'b1;
        @(posedge video_vsync);
        check_en = 1'b0;
        check_equal(pix_checked, H_ACTIVE * V_ACTIVE, "pixels compared in frame");
    endtask

    // comparing process, samples mid-cycle
    always @(negedge clk_pix) begin
        if (reset) begin
            px      = 0;
            ly      = 0;
            hs_cnt  = 0;
            hs_high = 0;
            vs_high = 0;
            hs_seen = 1'b0;
            de_q    = 1'b0;
            hs_q    = 1'b0;
            vs_q    = 1'b0;
        end else begin
            if (video_de) begin
                if (check_en) begin
                    check_equal({video_red, video_green, video_blue}, expected_rgb(px, ly),
                                $sformatf("pixel at x %0d y %0d", px, ly));
                    pix_checked++;
                end
                px++;
            end else if (de_q) begin  // end of an active line
                check_equal(px, H_ACTIVE, "de cycles in line");
                px = 0;
                ly++;
            end
            if (video_hsync && !hs_q) begin
                if (hs_seen)
                    check_equal(hs_cnt, H_TOTAL, "hsync period");
                hs_seen = 1'b1;
                hs_cnt  = 0;
            end
            hs_cnt++;
            if (video_hsync) begin
                hs_high++;
            end else if (hs_q) begin
                check_equal(hs_high, H_SYNC, "hsync width");
                hs_high = 0;
            end
            if (video_vsync && !vs_q) begin
                check_equal(ly, V_ACTIVE, "active lines in frame");
                ly = 0;
            end
            if (video_vsync) begin
                vs_high++;
            end else if (vs_q) begin
                check_equal(vs_high, V_SYNC * H_TOTAL, "vsync width");
                vs_high = 0;
            end
            de_q = video_de;
            hs_q = video_hsync;
            vs_q = video_vsync;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("test timed out, run still going after 10 frames");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] rd, wdata;
        clk_pix     = 1'b0;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        check_en    = 1'b0;
        pix_checked = 0;
        lfsr_state  = 32'h4c26;
        model_fill(4'd0);
        for (int n = 0; n < 16; n++)
            pal_model[n] = '0;
        repeat (3) @(posedge clk_pix);
        #1;
        check_equal({video_de, video_hsync, video_vsync}, 0, "sync outputs in reset");
        reset = 1'b0;

        apb_read(fb_pkg::REG_STATUS, rd, 1'b0);
        check_equal(rd, 0, "status after reset");
        for (int n = 0; n < 16; n++) begin
            apb_read(pal_reg(n), rd, 1'b0);
            check_equal(rd, 0, $sformatf("palette %0d after reset", n));
        end

        for (int n = 0; n < 16; n++) begin
            wdata = random_bits(32);
            apb_write(pal_reg(n), wdata, 1'b0);
            pal_model[n] = wdata[11:0];
        end
        for (int n = 0; n < 16; n++) begin
            apb_read(pal_reg(n), rd, 1'b0);
            check_equal(rd, {20'b0, pal_model[n]}, $sformatf("palette %0d readback", n));
        end
        apb_read(8'h20, rd, 1'b1);                 // unmapped
        apb_write(fb_pkg::REG_STATUS, 32'h1, 1'b1);  // read-only

        apb_write(fb_pkg::REG_CTRL, {24'b0, 4'd3, 2'b0, fb_pkg::CMD_FILL}, 1'b0);
        model_fill(4'd3);
        wait_idle();
        apb_read(fb_pkg::REG_STATUS, rd, 1'b0);
        check_equal(rd, 32'h100, "status after fill");
        check_frame();

        // outline, then a second command while the first is busy
        apb_write(fb_pkg::REG_CTRL, {24'b0, 4'd9, 2'b0, fb_pkg::CMD_BOX}, 1'b0);
        apb_write(fb_pkg::REG_CTRL, {24'b0, 4'd5, 2'b0, fb_pkg::CMD_FILL}, 1'b1);
        model_box(4'd9);
        wait_idle();
        apb_read(fb_pkg::REG_STATUS, rd, 1'b0);
        check_equal(rd, 32'h200, "status after outline");
        check_frame();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== project.f ====
src/fb_pkg.sv
src/display_timing.sv
src/fb_regs.sv
src/box_painter.sv
src/framebuffer.sv
src/fb_display_top.sv
+incdir+tb
tb/tb_fb_display.sv

// ==== Makefile ====
# Verilator build and run for the framebuffer display testbench
TOP := tb_fb_display

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f $(wildcard src/*.sv tb/*.sv tb/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
